//--- compile.f
verilog/otp_buf_pkg.sv
verilog/secded_72_64_enc.sv
verilog/secded_72_64_dec.sv
verilog/otp_buf_cmd_decode.sv
verilog/otp_ctrl_ecc_reg.sv
verilog/otp_buf_status.sv
verilog/otp_part_buf_top.sv
verif/otp_part_buf_assertions.sv
verif/otp_part_buf_tb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module otp_part_buf_tb -f compile.f
	out=$$(./obj_dir/Votp_part_buf_tb 2>&1); echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir

//--- verif/otp_part_buf_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench of the OTP partition word buffer. A cycle
// model tracks storage and status, a falling-edge
// process compares them with the DUT outputs.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module otp_part_buf_tb;
  import otp_buf_pkg::*;

  logic                  clk_i = 1'b0;
  logic                  rst_ni;
  logic                  wr_i;
  logic                  raw_i;
  logic                  lock_i;
  logic                  clr_err_i;
  logic [AddrWidth:0]    wr_addr_i;
  logic [AddrWidth:0]    rd_addr_i;
  ecc_word_t             wdata_i;
  ecc_word_t             rdata_o;
  ecc_word_t [Depth-1:0] data_o;
  buf_status_t           status_o;

  // Cycle model, decode register, shadow storage and expected status.
  ecc_word_t             shadow [Depth];
  logic                  m_locked;
  logic                  m_vld;
  logic                  m_rej;
  logic [AddrWidth-1:0]  m_addr;
  ecc_word_t             m_word;
  buf_status_t           exp_status;
  logic                  cmp_en;
  int                    errors;
  int                    checks;
  int                    e0;
  int                    rej_seen;
  int                    r0;
  integer                seed;
  logic [31:0]           rnd;
  logic [DataWidth-1:0]  d;
  ecc_word_t             w;
  ecc_word_t [Depth-1:0] snap;

  always #2 clk_i = ~clk_i;

  otp_part_buf_top dut (.*);

  // Inverted SECDED check bits from the mask rows.
  function automatic logic [EccWidth-1:0] ref_encode(input logic [DataWidth-1:0] data);
    logic [EccWidth-1:0] p;
    for (int i = 0; i < EccWidth; i++) begin
      p[i] = ^(data & SecdedMasks[i]);
    end
    return p ^ SecdedInvMask;
  endfunction

  // Bit 0 for an odd syndrome, bit 1 for a nonzero even one.
  function automatic logic [1:0] ref_classify(input ecc_word_t word);
    logic [EccWidth-1:0] syn;
    syn = ref_encode(word.data) ^ word.ecc;
    if (syn == '0) return 2'b00;
    if (^syn) return 2'b01;
    return 2'b10;
  endfunction

  task automatic check_val(input string name, input logic [71:0] got, input logic [71:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED t=%0t %s got=%h exp=%h", $time, name, got, exp);
    end
  endtask

  // One rising edge, the model samples the same inputs as the DUT.
  task automatic tick();
    logic [1:0] err_now;
    logic       accept;
    @(posedge clk_i);
    if (rst_ni) begin
      err_now = '0;
      for (int k = 0; k < Depth; k++) begin
        err_now = err_now | ref_classify(shadow[k]);
      end
      exp_status.wr_rejected = m_rej;
      exp_status.locked      = m_locked;
      if (clr_err_i) begin
        exp_status.ecc_err = 1'b0;
        exp_status.dbl_err = 1'b0;
      end else begin
        exp_status.ecc_err = exp_status.ecc_err | (|err_now);
        exp_status.dbl_err = exp_status.dbl_err | err_now[1];
      end
      // Store the command registered one edge earlier.
      if (m_vld) shadow[m_addr] = m_word;
      accept = wr_i && (int'(wr_addr_i) < Depth) && !m_locked;
      m_vld  = accept;
      m_rej  = wr_i && !accept;
      if (accept) begin
        m_addr = wr_addr_i[AddrWidth-1:0];
        if (raw_i) m_word = wdata_i;
        else m_word = '{ecc: ref_encode(wdata_i.data), data: wdata_i.data};
      end
      m_locked = m_locked | lock_i;
    end
  endtask

  task automatic idle_cycle();
    tick();
    wr_i      <= 1'b0;
    lock_i    <= 1'b0;
    clr_err_i <= 1'b0;
  endtask

  task automatic issue_write(input logic [AddrWidth:0] addr, input logic raw,
                             input ecc_word_t word);
    idle_cycle();
    wr_i      <= 1'b1;
    raw_i     <= raw;
    wr_addr_i <= addr;
    wdata_i   <= word;
    rd_addr_i <= addr;
  endtask

  // Waits for any masked status bit, bounded to 20 cycles.
  task automatic wait_flag(input buf_status_t mask, input string what);
    int n;
    n = 0;
    do begin
      idle_cycle();
      @(negedge clk_i);
      n++;
    end while (((status_o & mask) == '0) && (n < 20));
    if ((status_o & mask) == '0) begin
      errors++;
      $display("Timeout: %s did not rise within 20 cycles", what);
    end
  endtask

  task automatic report(input string name);
    $display("Test %-10s %s (%0d errors)", name, (errors == e0) ? "ok" : "FAILED", errors - e0);
    e0 = errors;
  endtask

  // Compare process, outputs are stable on the falling edge.
  always @(negedge clk_i) begin
    if (cmp_en) begin
      for (int k = 0; k < Depth; k++) begin
        check_val($sformatf("data_o[%0d]", k), data_o[k], shadow[k]);
      end
      check_val("rdata_o", rdata_o,
                (int'(rd_addr_i) < Depth) ? shadow[rd_addr_i[AddrWidth-1:0]] : '0);
      check_val("status_o", 72'(status_o), 72'(exp_status));
      if (status_o.wr_rejected) rej_seen++;
    end
  end

  initial begin
    rst_ni    = 1'b0;
    wr_i      = 1'b0;
    raw_i     = 1'b0;
    lock_i    = 1'b0;
    clr_err_i = 1'b0;
    wr_addr_i = '0;
    rd_addr_i = '0;
    wdata_i   = '0;
    seed      = 32'h2c64;
    errors    = 0;
    checks    = 0;
    e0        = 0;
    rej_seen  = 0;
    cmp_en    = 1'b0;
    for (int k = 0; k < Depth; k++) shadow[k] = '{ecc: SecdedZeroEcc, data: '0};
    m_locked   = 1'b0;
    m_vld      = 1'b0;
    m_rej      = 1'b0;
    m_addr     = '0;
    m_word     = '0;
    exp_status = '0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    cmp_en = 1'b1;

    // Reset state.
    @(negedge clk_i);
    for (int k = 0; k < Depth; k++) check_val("data_o.data", 72'(data_o[k].data), '0);
    check_val("status_o", 72'(status_o), '0);
    report("reset");

    // Back-to-back encoded writes, the given check bits are junk.
    repeat (12) begin
      rnd      = $random(seed);
      d[63:32] = $random(seed);
      d[31:0]  = $random(seed);
      w        = '{ecc: rnd[15:8], data: d};
      issue_write({1'b0, rnd[AddrWidth-1:0]}, 1'b0, w);
      rd_addr_i <= rnd[7:4];
    end
    repeat (3) idle_cycle();
    @(negedge clk_i);
    w = '{ecc: ref_encode(d), data: d};
    check_val("data_o last write", data_o[rnd[AddrWidth-1:0]], w);
    check_val("status_o.ecc_err", 72'(status_o.ecc_err), '0);
    report("encoded");

    // Raw words with one and with two flipped bits.
    d[63:32] = $random(seed);
    d[31:0]  = $random(seed);
    w = '{ecc: ref_encode(d), data: d};
    w.data[5] = ~w.data[5];
    check_val("class of one flip", 72'(ref_classify(w)), 72'(2'b01));
    issue_write(4'd2, 1'b1, w);
    wait_flag('{ecc_err: 1'b1, default: 1'b0}, "ecc_err");
    check_val("status_o.dbl_err", 72'(status_o.dbl_err), '0);
    w.data[5]  = ~w.data[5];
    w.data[10] = ~w.data[10];
    w.data[40] = ~w.data[40];
    check_val("class of two flips", 72'(ref_classify(w)), 72'(2'b10));
    issue_write(4'd5, 1'b1, w);
    wait_flag('{dbl_err: 1'b1, default: 1'b0}, "dbl_err");
    check_val("status_o.ecc_err", 72'(status_o.ecc_err), 72'(1));
    // Encoded rewrites repair both words, then the flags are cleared.
    issue_write(4'd2, 1'b0, w);
    issue_write(4'd5, 1'b0, w);
    repeat (3) idle_cycle();
    idle_cycle();
    clr_err_i <= 1'b1;
    repeat (2) idle_cycle();
    @(negedge clk_i);
    check_val("status_o error flags", 72'({status_o.ecc_err, status_o.dbl_err}), '0);
    report("raw_errors");

    // Out-of-range write and read.
    snap = data_o;
    r0   = rej_seen;
    issue_write(4'd9, 1'b0, w);
    repeat (4) idle_cycle();
    rd_addr_i <= 4'd12;
    @(negedge clk_i);
    check_val("wr_rejected cycles", 72'(rej_seen - r0), 72'(1));
    check_val("rdata_o out of range", rdata_o, '0);
    for (int k = 0; k < Depth; k++) check_val("data_o kept", data_o[k], snap[k]);
    report("range");

    // Lock, then four writes that must all bounce.
    idle_cycle();
    lock_i <= 1'b1;
    wait_flag('{locked: 1'b1, default: 1'b0}, "locked");
    snap = data_o;
    r0   = rej_seen;
    repeat (4) begin
      rnd = $random(seed);
      issue_write({1'b0, rnd[AddrWidth-1:0]}, rnd[8], w);
    end
    repeat (4) idle_cycle();
    @(negedge clk_i);
    check_val("wr_rejected cycles", 72'(rej_seen - r0), 72'(4));
    check_val("status_o.locked", 72'(status_o.locked), 72'(1));
    for (int k = 0; k < Depth; k++) check_val("data_o kept", data_o[k], snap[k]);
    report("lock");

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/otp_part_buf_assertions.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Concurrent checks of a pulse, a lock level and a
// status vector. Bound into the decode and result stages.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module otp_part_buf_assertions (
  input logic       clk_i,
  input logic       rst_ni,
  input logic       pulse_i,
  input logic       cause_i,
  input logic       lock_i,
  input logic [3:0] watch_i
);

  // Each pulse cycle needs its own rejected strobe one cycle before.
  pulse_has_cause: assert property (
    @(posedge clk_i) disable iff (!rst_ni) pulse_i |-> $past(cause_i)
  ) else $error("reject pulse without a rejected strobe before it");

  // Lock is sticky until reset.
  lock_held: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !$fell(lock_i)
  ) else $error("lock level fell without reset");

  no_unknown: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !$isunknown(watch_i)
  ) else $error("unknown value on watched outputs");

endmodule

bind otp_buf_status otp_part_buf_assertions u_status_sva (
  .clk_i  (clk_i),
  .rst_ni (rst_ni),
  .pulse_i(status_o.wr_rejected),
  .cause_i(reject_i),
  .lock_i (status_o.locked),
  .watch_i(status_o)
);

// A strobe is rejected when its address is beyond the buffer or the lock is set.
// Only the control bits of the decode stage are watched.
bind otp_buf_cmd_decode otp_part_buf_assertions u_decode_sva (
  .clk_i  (clk_i),
  .rst_ni (rst_ni),
  .pulse_i(reject_o),
  .cause_i(wr_i & ((32'(wr_addr_i) >= otp_buf_pkg::Depth) | locked_o)),
  .lock_i (locked_o),
  .watch_i({cmd_o.wr_en, reject_o, locked_o, lock_i})
);

`default_nettype wire

//--- verilog/otp_part_buf_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Word buffer of one buffered OTP partition. Chains
// the decode, execute and result stages.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module otp_part_buf_top (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  input  logic                                            wr_i,
  input  logic                                            raw_i,
  input  logic [otp_buf_pkg::AddrWidth:0]                 wr_addr_i,
  input  otp_buf_pkg::ecc_word_t                          wdata_i,
  input  logic                                            lock_i,
  input  logic [otp_buf_pkg::AddrWidth:0]                 rd_addr_i,
  input  logic                                            clr_err_i,
  output otp_buf_pkg::ecc_word_t                          rdata_o,
  output otp_buf_pkg::ecc_word_t [otp_buf_pkg::Depth-1:0] data_o,
  output otp_buf_pkg::buf_status_t                        status_o
);

  import otp_buf_pkg::*;

  buf_cmd_t   cmd;
  logic       reject;
  logic       locked;
  logic [1:0] err;

  // Range and lock check, command register.
  otp_buf_cmd_decode u_decode (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wr_i     (wr_i),
    .raw_i    (raw_i),
    .wr_addr_i(wr_addr_i),
    .wdata_i  (wdata_i),
    .lock_i   (lock_i),
    .cmd_o    (cmd),
    .reject_o (reject),
    .locked_o (locked)
  );

  // Storage and checkers.
  otp_ctrl_ecc_reg u_ecc_reg (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .cmd_i    (cmd),
    .rd_addr_i(rd_addr_i),
    .rdata_o  (rdata_o),
    .data_o   (data_o),
    .err_o    (err)
  );

  // Registered status.
  otp_buf_status u_status (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .err_i    (err),
    .reject_i (reject),
    .locked_i (locked),
    .clr_err_i(clr_err_i),
    .status_o (status_o)
  );

endmodule

`default_nettype wire

//--- verilog/otp_buf_status.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Result stage. Turns raw error, reject and lock
// signals into the registered buffer status.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module otp_buf_status (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Bit 0 is single or odd weight, bit 1 is double.
  input  logic [1:0]               err_i,
  input  logic                     reject_i,
  input  logic                     locked_i,
  input  logic                     clr_err_i,
  output otp_buf_pkg::buf_status_t status_o
);

  import otp_buf_pkg::*;

  buf_status_t status_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      status_q <= '0;
    end else begin
      // Reject is a one-cycle pulse, lock a level.
      status_q.wr_rejected <= reject_i;
      status_q.locked      <= locked_i;
      if (clr_err_i) begin
        // Clear wins for this edge.
        // A lasting error sets the flags again on the next one.
        status_q.ecc_err <= 1'b0;
        status_q.dbl_err <= 1'b0;
      end else begin
        status_q.ecc_err <= status_q.ecc_err | (|err_i);
        status_q.dbl_err <= status_q.dbl_err | err_i[1];
      end
    end
  end

  assign status_o = status_q;

endmodule

`default_nettype wire

//--- verilog/otp_ctrl_ecc_reg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute stage. ECC register file of the buffered
// partition, with parallel checks of every word.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module otp_ctrl_ecc_reg (
  input  logic                                               clk_i,
  input  logic                                               rst_ni,
  input  otp_buf_pkg::buf_cmd_t                              cmd_i,
  input  logic [otp_buf_pkg::AddrWidth:0]                    rd_addr_i,
  output otp_buf_pkg::ecc_word_t                             rdata_o,
  // All words at once.
  output otp_buf_pkg::ecc_word_t [otp_buf_pkg::Depth-1:0]    data_o,
  // Bit 0 is single or odd weight, bit 1 is double.
  output logic [1:0]                                         err_o
);

  import otp_buf_pkg::*;

  ecc_word_t [Depth-1:0]   mem_q;
  ecc_word_t               wr_word;
  logic [EccWidth-1:0]     enc_ecc;
  logic [Depth-1:0][1:0]   word_err;

  // A single encoder serves every write.
  secded_72_64_enc u_enc (
    .data_i(cmd_i.word.data),
    .ecc_o (enc_ecc)
  );

  // Raw writes keep their own check bits.
  assign wr_word = cmd_i.raw ? cmd_i.word : '{ecc: enc_ecc, data: cmd_i.word.data};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      // Zero words with valid check bits, so no error after reset.
      for (int k = 0; k < Depth; k++) begin
        mem_q[k] <= '{ecc: SecdedZeroEcc, data: '0};
      end
    end else if (cmd_i.wr_en) begin
      mem_q[cmd_i.addr] <= wr_word;
    end
  end

  // Addressed read, zero when out of range.
  always_comb begin
    rdata_o = '0;
    if (32'(rd_addr_i) < Depth) begin
      rdata_o = mem_q[rd_addr_i[AddrWidth-1:0]];
    end
  end

  assign data_o = mem_q;

  // One checker per stored word.
  for (genvar k = 0; k < Depth; k++) begin : gen_dec
    secded_72_64_dec u_dec (
      .word_i(mem_q[k]),
      .err_o (word_err[k])
    );
  end

  // Merge the flags of all words.
  always_comb begin
    err_o = '0;
    for (int k = 0; k < Depth; k++) begin
      err_o = err_o | word_err[k];
    end
  end

endmodule

`default_nettype wire

//--- verilog/otp_buf_cmd_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode stage of the word buffer. Checks lock and
// address range, registers one command per cycle.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module otp_buf_cmd_decode (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            wr_i,
  input  logic                            raw_i,
  // One extra bit so that out-of-range addresses can be seen.
  input  logic [otp_buf_pkg::AddrWidth:0] wr_addr_i,
  input  otp_buf_pkg::ecc_word_t          wdata_i,
  input  logic                            lock_i,
  output otp_buf_pkg::buf_cmd_t           cmd_o,
  output logic                            reject_o,
  output logic                            locked_o
);

  import otp_buf_pkg::*;

  logic                 locked_q;
  logic                 in_range;
  logic                 accept;
  logic                 wr_en_q;
  logic                 reject_q;
  logic                 raw_q;
  logic [AddrWidth-1:0] addr_q;
  ecc_word_t            word_q;

  assign in_range = 32'(wr_addr_i) < Depth;

  // A strobe in the lock cycle itself still goes through.
  assign accept = wr_i & in_range & ~locked_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      locked_q <= 1'b0;
      wr_en_q  <= 1'b0;
      reject_q <= 1'b0;
    end else begin
      // Lock is sticky until reset.
      locked_q <= locked_q | lock_i;
      wr_en_q  <= accept;
      reject_q <= wr_i & ~accept;
    end
  end

  // Command payload, only loaded for accepted strobes.
  always_ff @(posedge clk_i) begin
    if (accept) begin
      raw_q  <= raw_i;
      addr_q <= wr_addr_i[AddrWidth-1:0];
      word_q <= wdata_i;
    end
  end

  assign cmd_o    = '{wr_en: wr_en_q, raw: raw_q, addr: addr_q, word: word_q};
  assign reject_o = reject_q;
  assign locked_o = locked_q;

endmodule

`default_nettype wire

//--- verilog/secded_72_64_dec.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Inverted 72/64 SECDED checker. Flags single (odd
// syndrome) and double (even syndrome) errors.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module secded_72_64_dec (
  input  otp_buf_pkg::ecc_word_t word_i,
  // Bit 0 is single or odd weight, bit 1 is double.
  output logic [1:0]             err_o
);

  import otp_buf_pkg::*;

  logic [EccWidth-1:0] calc_ecc;
  logic [EccWidth-1:0] syndrome;

  // Recompute the check bits of the stored data.
  secded_72_64_enc u_enc (
    .data_i(word_i.data),
    .ecc_o (calc_ecc)
  );

  // Both sides carry the inversion, so it cancels here.
  assign syndrome = calc_ecc ^ word_i.ecc;

  // Every Hsiao column has odd weight.
  // A single flip thus leaves an odd syndrome.
  assign err_o[0] = ^syndrome;

  // Two flips give a nonzero syndrome of even weight.
  assign err_o[1] = (|syndrome) & ~(^syndrome);

  // Correction is not needed, detection only.

endmodule

`default_nettype wire

//--- verilog/secded_72_64_enc.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Inverted 72/64 SECDED encoder. Purely combinational,
// gives the 8 check bits for a 64-bit data word.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module secded_72_64_enc (
  input  logic [otp_buf_pkg::DataWidth-1:0] data_i,
  output logic [otp_buf_pkg::EccWidth-1:0]  ecc_o
);

  import otp_buf_pkg::*;

  // Raw parity of each masked group.
  logic [EccWidth-1:0] parity;

  always_comb begin
    for (int i = 0; i < EccWidth; i++) begin
      // Each check bit covers the data bits its mask selects.
      parity[i] = ^(data_i & SecdedMasks[i]);
    end
  end

  // Invert the fixed check bit pattern.
  assign ecc_o = parity ^ SecdedInvMask;

endmodule

`default_nettype wire

//--- verilog/otp_buf_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths, SECDED constants and structs of the
// OTP partition word buffer. Modules import it.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package otp_buf_pkg;

  // Payload and check bit widths of one buffered word.
  localparam int DataWidth = 64;
  localparam int EccWidth  = 8;

  // Number of buffered words and their address width.
  localparam int Depth     = 8;
  localparam int AddrWidth = 3;

  // Hsiao masks, entry i selects the data bits covered by check bit i.
  localparam logic [EccWidth-1:0][DataWidth-1:0] SecdedMasks = {
    64'h7AED348D221A4420,
    64'hCBDAAA4A91152210,
    64'hB5B65926488C9108,
    64'hB671C711C4438884,
    64'hCD0FC0F03C207842,
    64'h67003FF003E007C1,
    64'h5E00000FFFE0003F,
    64'hB9000000001FFFFF
  };

  // Inversion keeps an all-zero word from being a valid codeword.
  localparam logic [EccWidth-1:0] SecdedInvMask = 8'hAA;

  // Check bits of all-zero data (parity is zero, so only the inversion remains).
  localparam logic [EccWidth-1:0] SecdedZeroEcc = SecdedInvMask;

  // One stored word, check bits on top as in the macro image.
  typedef struct packed {
    logic [EccWidth-1:0]  ecc;
    logic [DataWidth-1:0] data;
  } ecc_word_t;

  // Command from the decode stage to the register file.
  typedef struct packed {
    logic                 wr_en;
    logic                 raw;
    logic [AddrWidth-1:0] addr;
    ecc_word_t            word;
  } buf_cmd_t;

  // Registered status of the buffer.
  typedef struct packed {
    logic ecc_err;
    logic dbl_err;
    logic wr_rejected;
    logic locked;
  } buf_status_t;

endpackage

`default_nettype wire
